/* verilog/cc_pkg.sv */
`default_nettype none

package cc_pkg;

    // request path.
    localparam int REQ_W = 32;

    // ecn marking ratio, one marked request after PACKET_GAP unmarked ones.
    localparam int PACKET_GAP = 5;
    localparam int MARK_CNT_W = 3;

    // measurement window, in cycles.
    localparam int MEASURE_GAP = 50;
    localparam int WIN_W = 6;

    // request queue.
    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_AW = 3;

    // inter-request gap, in idle cycles.
    localparam int GAP_W = 4;
    localparam int GAP_MAX = 15;
    localparam int GAP_INC = 4;   // step up after a window with marks.

endpackage

`default_nettype wire

/* verilog/ecn_marker.sv */
`default_nettype none

module ecn_marker
    import cc_pkg::*;
(
    input  logic             aclk,
    input  logic             aresetn,

    input  logic             s_valid,
    output logic             s_ready,
    input  logic [REQ_W-1:0] s_data,

    output logic             mk_valid,
    input  logic             mk_ready,
    output logic [REQ_W-1:0] mk_data,
    output logic             mk_mark
);

    logic [MARK_CNT_W-1:0] pos_cnt;   // position inside the current group of six.
    logic                  fire;
    logic                  last_pos;

    // data path is pure pass-through, only the mark is added.
    assign mk_valid = s_valid;
    assign s_ready  = mk_ready;
    assign mk_data  = s_data;

    assign fire     = s_valid && mk_ready;
    assign last_pos = (pos_cnt == MARK_CNT_W'(PACKET_GAP));
    assign mk_mark  = last_pos;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pos_cnt <= '0;
        end else if (fire) begin
            if (last_pos) begin
                pos_cnt <= '0;   // wrap after the marked request.
            end else begin
                pos_cnt <= pos_cnt + 1'b1;
            end
        end
    end

    // counter stays inside the group.
    a_pos_range: assert property (
        @(posedge aclk) disable iff (!aresetn)
        pos_cnt <= MARK_CNT_W'(PACKET_GAP)
    );

endmodule

`default_nettype wire

/* verilog/req_queue.sv */
`default_nettype none

module req_queue
    import cc_pkg::*;
(
    input  logic             aclk,
    input  logic             aresetn,

    input  logic             wr_valid,
    output logic             wr_ready,
    input  logic [REQ_W-1:0] wr_data,
    input  logic             wr_mark,

    output logic             rd_valid,
    input  logic             rd_ready,
    output logic [REQ_W-1:0] rd_data,
    output logic             rd_mark
);

    logic [REQ_W-1:0]  mem_data [QUEUE_DEPTH];
    logic              mem_mark [QUEUE_DEPTH];

    logic [QUEUE_AW-1:0] wr_ptr;
    logic [QUEUE_AW-1:0] rd_ptr;
    logic [QUEUE_AW:0]   count;   // one bit wider so full is distinct from empty.

    logic do_wr;
    logic do_rd;

    assign wr_ready = (count != (QUEUE_AW + 1)'(QUEUE_DEPTH));
    assign rd_valid = (count != '0);

    assign do_wr = wr_valid && wr_ready;
    assign do_rd = rd_valid && rd_ready;

    // head of queue straight from storage.
    assign rd_data = mem_data[rd_ptr];
    assign rd_mark = mem_mark[rd_ptr];

    always_ff @(posedge aclk) begin
        if (do_wr) begin
            mem_data[wr_ptr] <= wr_data;
            mem_mark[wr_ptr] <= wr_mark;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, wraps itself.
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither.
            endcase
        end
    end

    a_count_range: assert property (
        @(posedge aclk) disable iff (!aresetn)
        count <= (QUEUE_AW + 1)'(QUEUE_DEPTH)
    );

    // read pointer only moves when there was something to read.
    a_no_empty_read: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (rd_ptr != $past(rd_ptr)) |-> ($past(count) != '0)
    );

endmodule

`default_nettype wire

/* verilog/req_pacer.sv */
`default_nettype none

module req_pacer
    import cc_pkg::*;
(
    input  logic             aclk,
    input  logic             aresetn,

    input  logic             q_valid,
    output logic             q_ready,
    input  logic [REQ_W-1:0] q_data,
    input  logic             q_mark,

    output logic             m_valid,
    input  logic             m_ready,
    output logic [REQ_W-1:0] m_data,
    output logic             m_mark,

    input  logic [GAP_W-1:0] cur_gap,
    output logic             out_mark_pulse
);

    logic [GAP_W-1:0] idle_cnt;   // idle cycles left before the next release.
    logic             open;
    logic             m_fire;

    assign open = (idle_cnt == '0);

    // gate the queue head with the idle counter.
    assign m_valid = q_valid && open;
    assign q_ready = m_ready && open;
    assign m_data  = q_data;
    assign m_mark  = q_mark;

    assign m_fire         = m_valid && m_ready;
    assign out_mark_pulse = m_fire && q_mark;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            idle_cnt <= '0;
        end else if (m_fire) begin
            idle_cnt <= cur_gap;   // gap sampled at the transfer.
        end else if (!open) begin
            idle_cnt <= idle_cnt - 1'b1;
        end
    end

    // output must not drop or change before it is taken.
    // relies on the queue keeping its head while unread.
    a_valid_hold: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_mark))
    );

endmodule

`default_nettype wire

/* verilog/cc_rate_ctrl.sv */
`default_nettype none

module cc_rate_ctrl
    import cc_pkg::*;
(
    input  logic             aclk,
    input  logic             aresetn,

    input  logic             in_fire,
    input  logic             out_mark_pulse,
    output logic [GAP_W-1:0] cur_gap
);

    logic             running;     // set by the first input transfer.
    logic [WIN_W-1:0] win_cnt;
    logic             mark_seen;   // any mark left the path in this window.
    logic             win_end;
    logic             seen_any;
    logic [GAP_W:0]   gap_up;      // one spare bit for the saturation check.
    logic [GAP_W-1:0] gap_next;

    assign win_end  = running && (win_cnt == WIN_W'(MEASURE_GAP - 1));
    assign seen_any = mark_seen || out_mark_pulse;   // last cycle's mark counts too.
    assign gap_up   = {1'b0, cur_gap} + (GAP_W + 1)'(GAP_INC);

    // widen after congestion, otherwise narrow by one.
    always_comb begin
        if (seen_any) begin
            if (gap_up > (GAP_W + 1)'(GAP_MAX)) begin
                gap_next = GAP_W'(GAP_MAX);
            end else begin
                gap_next = gap_up[GAP_W-1:0];
            end
        end else if (cur_gap != '0) begin
            gap_next = cur_gap - 1'b1;
        end else begin
            gap_next = '0;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            running   <= 1'b0;
            win_cnt   <= '0;
            mark_seen <= 1'b0;
            cur_gap   <= '0;
        end else if (!running) begin
            if (in_fire) begin
                running <= 1'b1;
                win_cnt <= '0;   // first window starts next cycle.
            end
        end else if (win_end) begin
            win_cnt   <= '0;
            mark_seen <= 1'b0;
            cur_gap   <= gap_next;
        end else begin
            win_cnt   <= win_cnt + 1'b1;
            mark_seen <= seen_any;
        end
    end

    a_gap_max: assert property (
        @(posedge aclk) disable iff (!aresetn)
        cur_gap <= GAP_W'(GAP_MAX)
    );

endmodule

`default_nettype wire

/* verilog/cc_top.sv */
`default_nettype none

module cc_top
    import cc_pkg::*;
(
    input  logic             aclk,
    input  logic             aresetn,

    input  logic             s_valid,
    output logic             s_ready,
    input  logic [REQ_W-1:0] s_data,

    output logic             m_valid,
    input  logic             m_ready,
    output logic [REQ_W-1:0] m_data,
    output logic             m_mark,

    output logic [GAP_W-1:0] cur_gap
);

    logic             mk_valid;
    logic             mk_ready;
    logic [REQ_W-1:0] mk_data;
    logic             mk_mark;

    logic             q_valid;
    logic             q_ready;
    logic [REQ_W-1:0] q_data;
    logic             q_mark;

    logic             out_mark_pulse;
    logic             in_fire;

    assign in_fire = s_valid && s_ready;   // starts the measurement windows.

    ecn_marker u_marker (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .s_valid  (s_valid),
        .s_ready  (s_ready),
        .s_data   (s_data),
        .mk_valid (mk_valid),
        .mk_ready (mk_ready),
        .mk_data  (mk_data),
        .mk_mark  (mk_mark)
    );

    req_queue u_queue (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .wr_valid (mk_valid),
        .wr_ready (mk_ready),
        .wr_data  (mk_data),
        .wr_mark  (mk_mark),
        .rd_valid (q_valid),
        .rd_ready (q_ready),
        .rd_data  (q_data),
        .rd_mark  (q_mark)
    );

    req_pacer u_pacer (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .q_valid        (q_valid),
        .q_ready        (q_ready),
        .q_data         (q_data),
        .q_mark         (q_mark),
        .m_valid        (m_valid),
        .m_ready        (m_ready),
        .m_data         (m_data),
        .m_mark         (m_mark),
        .cur_gap        (cur_gap),
        .out_mark_pulse (out_mark_pulse)
    );

    cc_rate_ctrl u_rate_ctrl (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .in_fire        (in_fire),
        .out_mark_pulse (out_mark_pulse),
        .cur_gap        (cur_gap)
    );

endmodule

`default_nettype wire

/* verification/tb_cc_top.sv */
`default_nettype none

module tb_cc_top
    import cc_pkg::*;
;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_CYCLES = 1600;
    localparam int FILL_START = 400;   // sink stalls from here.
    localparam int FILL_END = 500;
    localparam int DRAIN_START = 1300;   // no new requests, sink always ready.
    localparam int MARGIN = 100;

    logic             aclk;
    logic             aresetn;
    logic             s_valid;
    logic             s_ready;
    logic [REQ_W-1:0] s_data;
    logic             m_valid;
    logic             m_ready;
    logic [REQ_W-1:0] m_data;
    logic             m_mark;
    logic [GAP_W-1:0] cur_gap;

    integer seed;
    int data_errs, mark_errs, gap_errs, other_errs;

    // reference model state.
    logic [REQ_W-1:0] exp_data [$];
    logic             exp_mark [$];
    logic [REQ_W-1:0] head_data;
    logic             head_mark;
    int  in_idx, occ, cycle, prev_out_cycle, prev_gap, exp_gap, win_cnt;
    bit  have_prev, running, win_seen, gap_pending, in_fire, out_fire, hold;

    cc_top uut (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_data  (s_data),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_data  (m_data),
        .m_mark  (m_mark),
        .cur_gap (cur_gap)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    task automatic compare_data(input string name, input logic [REQ_W-1:0] exp,
                                input logic [REQ_W-1:0] act);
        if (exp !== act) begin
            data_errs++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_mark(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            mark_errs++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic compare_gap(input string name, input logic [GAP_W-1:0] exp,
                               input logic [GAP_W-1:0] act);
        if (exp !== act) begin
            gap_errs++;
            $display("error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // monitor and model, sampled mid-cycle where everything is settled.
    always @(negedge aclk) begin
        if (aresetn) begin
            if (gap_pending) begin
                compare_gap("window_gap", GAP_W'(exp_gap), cur_gap);
                gap_pending = 0;
            end
            if (occ == QUEUE_DEPTH) compare_mark("s_ready_full", 1'b0, s_ready);
            in_fire  = s_valid && s_ready;
            out_fire = m_valid && m_ready;
            head_mark = 1'b0;
            if (out_fire) begin
                if (exp_data.size() == 0) begin
                    other_errs++;
                    $display("output transfer in cycle %0d with no word expected", cycle);
                end else begin
                    head_data = exp_data.pop_front();
                    head_mark = exp_mark.pop_front();
                    compare_data("out_data", head_data, m_data);
                    compare_mark("out_mark", head_mark, m_mark);
                end
                if (have_prev && (cycle - prev_out_cycle - 1) < prev_gap) begin
                    other_errs++;
                    $display("pacing broken in cycle %0d: %0d idle cycles, gap was %0d",
                             cycle, cycle - prev_out_cycle - 1, prev_gap);
                end
                have_prev = 1;
                prev_out_cycle = cycle;
                prev_gap = exp_gap;   // gap in force at the transfer.
            end
            if (in_fire) begin
                exp_data.push_back(s_data);
                exp_mark.push_back((in_idx % (PACKET_GAP + 1)) == PACKET_GAP);
                in_idx++;
            end
            // window rule mirror.
            if (running) begin
                if (out_fire && head_mark) win_seen = 1;
                if (win_cnt == MEASURE_GAP - 1) begin
                    if (win_seen) exp_gap = (exp_gap + GAP_INC > GAP_MAX) ? GAP_MAX
                                                                         : exp_gap + GAP_INC;
                    else if (exp_gap > 0) exp_gap = exp_gap - 1;
                    gap_pending = 1;
                    win_cnt = 0;
                    win_seen = 0;
                end else begin
                    win_cnt++;
                end
            end else if (in_fire) begin
                running = 1;
                win_cnt = 0;
            end
            occ = occ + int'(in_fire) - int'(out_fire);
            hold = s_valid && !s_ready;   // source must keep this word.
            cycle++;
        end
    end

    initial begin
        seed = 32'h322ebca8;
        aclk = 1'b0;
        aresetn = 1'b0;
        s_valid = 1'b0;
        s_data = '0;
        m_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        #2 aresetn = 1'b1;
        @(negedge aclk);
        compare_mark("reset_s_ready", 1'b1, s_ready);
        compare_mark("reset_m_valid", 1'b0, m_valid);
        compare_gap("reset_gap", '0, cur_gap);
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge aclk);
            #2;
            if (!hold) begin
                s_valid = (i < DRAIN_START) && (($random(seed) & 3) != 0);
                s_data = $random(seed);
            end
            if (i >= FILL_START && i < FILL_END) m_ready = 1'b0;   // let the queue fill.
            else if (i >= DRAIN_START) m_ready = 1'b1;
            else m_ready = ($random(seed) & 1) != 0;
        end
        @(posedge aclk);   // last monitor pass is done by now.
        if (exp_data.size() != 0) begin
            other_errs++;
            $display("%0d words never left the queue", exp_data.size());
        end
        $display("data errors %0d, mark errors %0d, gap errors %0d, other errors %0d",
                 data_errs, mark_errs, gap_errs, other_errs);
        if (data_errs + mark_errs + gap_errs + other_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog.
    initial begin
        #((NUM_CYCLES + RESET_CYCLES + MARGIN) * CLK_PERIOD);
        $display("timeout, the run did not reach its end in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* cc_subsystem.f */
verilog/cc_pkg.sv
verilog/ecn_marker.sv
verilog/req_queue.sv
verilog/req_pacer.sv
verilog/cc_rate_ctrl.sv
verilog/cc_top.sv
verification/tb_cc_top.sv

/* Bender.yml */
package:
  name: cc_subsystem

sources:
  - files:
      - verilog/cc_pkg.sv
      - verilog/ecn_marker.sv
      - verilog/req_queue.sv
      - verilog/req_pacer.sv
      - verilog/cc_rate_ctrl.sv
      - verilog/cc_top.sv
  - target: test
    files:
      - verification/tb_cc_top.sv
